/* design/rv_exec_defines.svh */
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

// datapath and address width.
`define RV_EXEC_XLEN 32

// scratch data memory size in words.
`define RV_EXEC_MEM_WORDS 256

// alu op codes.
`define RV_EXEC_ALU_ADD  4'd0
`define RV_EXEC_ALU_SUB  4'd1
`define RV_EXEC_ALU_SLL  4'd2
`define RV_EXEC_ALU_SLT  4'd3
`define RV_EXEC_ALU_SLTU 4'd4
`define RV_EXEC_ALU_XOR  4'd5
`define RV_EXEC_ALU_SRL  4'd6
`define RV_EXEC_ALU_SRA  4'd7
`define RV_EXEC_ALU_OR   4'd8
`define RV_EXEC_ALU_AND  4'd9
// a <= b, decode swaps the operands for bge and bgeu.
`define RV_EXEC_ALU_SLE  4'd10
`define RV_EXEC_ALU_SLEU 4'd11

// csr funct3 codes.
`define RV_EXEC_F3_CSRRW  3'b001
`define RV_EXEC_F3_CSRRS  3'b010
`define RV_EXEC_F3_CSRRC  3'b011
`define RV_EXEC_F3_CSRRWI 3'b101
`define RV_EXEC_F3_CSRRSI 3'b110
`define RV_EXEC_F3_CSRRCI 3'b111

`endif

/* design/rv_decode_pkg.sv */
package rv_decode_pkg;

  // register-register layout.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  // immediate layout, also carries the csr address.
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  // one instruction word, two decodings.
  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
  } inst_word_u;

  typedef logic [3:0] alu_op_t;

endpackage

/* design/rv_csr_pkg.sv */
package rv_csr_pkg;

  typedef logic [11:0] csr_addr_t;

  // machine level registers kept by the stage.
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  // environment call from m-mode.
  localparam int unsigned MCAUSE_ECALL_M = 11;

  // mstatus fields touched on trap entry and return.
  localparam int unsigned MSTATUS_MIE  = 3;
  localparam int unsigned MSTATUS_MPIE = 7;

endpackage

/* design/exec_alu.sv */
`include "rv_exec_defines.svh"

module exec_alu (
  input  logic [`RV_EXEC_XLEN-1:0] a,
  input  logic [`RV_EXEC_XLEN-1:0] b,
  input  rv_decode_pkg::alu_op_t   op,
  output logic [`RV_EXEC_XLEN-1:0] result
);

  logic [4:0] shamt;
  logic       lt;
  logic       ltu;
  logic       le;
  logic       leu;

  assign shamt = b[4:0];
  assign lt    = $signed(a) < $signed(b);
  assign ltu   = a < b;
  assign le    = $signed(a) <= $signed(b);
  assign leu   = a <= b;

  always_comb begin
    case (op)
      `RV_EXEC_ALU_ADD:  result = a + b;
      `RV_EXEC_ALU_SUB:  result = a - b;
      `RV_EXEC_ALU_SLL:  result = a << shamt;
      `RV_EXEC_ALU_SLT:  result = {{(`RV_EXEC_XLEN-1){1'b0}}, lt};
      `RV_EXEC_ALU_SLTU: result = {{(`RV_EXEC_XLEN-1){1'b0}}, ltu};
      `RV_EXEC_ALU_XOR:  result = a ^ b;
      `RV_EXEC_ALU_SRL:  result = a >> shamt;
      `RV_EXEC_ALU_SRA:  result = $signed(a) >>> shamt; // sign fill.
      `RV_EXEC_ALU_OR:   result = a | b;
      `RV_EXEC_ALU_AND:  result = a & b;
      `RV_EXEC_ALU_SLE:  result = {{(`RV_EXEC_XLEN-1){1'b0}}, le};
      `RV_EXEC_ALU_SLEU: result = {{(`RV_EXEC_XLEN-1){1'b0}}, leu};
      default:           result = '0;
    endcase
  end

endmodule

/* design/exec_csr_file.sv */
`include "rv_exec_defines.svh"

module exec_csr_file (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         wen,
  input  logic                         valid,
  input  logic                         ecall,
  input  logic                         mret,
  input  rv_csr_pkg::csr_addr_t        addr,
  input  logic [`RV_EXEC_XLEN-1:0]     wdata,
  input  logic [`RV_EXEC_XLEN-1:0]     pc,
  output logic [`RV_EXEC_XLEN-1:0]     rdata,
  output logic [`RV_EXEC_XLEN-1:0]     mepc,
  output logic [`RV_EXEC_XLEN-1:0]     mtvec
);
  import rv_csr_pkg::*;

  logic [`RV_EXEC_XLEN-1:0] mstatus;
  logic [`RV_EXEC_XLEN-1:0] mcause;

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (valid) begin
      if (ecall) begin
        // trap entry, stack the interrupt enable.
        mepc                  <= pc;
        mcause                <= MCAUSE_ECALL_M;
        mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
        mstatus[MSTATUS_MIE]  <= 1'b0;
      end else if (mret) begin
        mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
        mstatus[MSTATUS_MPIE] <= 1'b1;
      end else if (wen) begin
        case (addr)
          CSR_MSTATUS: mstatus <= wdata;
          CSR_MTVEC:   mtvec   <= wdata;
          CSR_MEPC:    mepc    <= wdata;
          CSR_MCAUSE:  mcause  <= wdata;
          default:     ; // writes to unknown csrs are dropped.
        endcase
      end
    end
  end

  always_comb begin
    case (addr)
      CSR_MSTATUS: rdata = mstatus;
      CSR_MTVEC:   rdata = mtvec;
      CSR_MEPC:    rdata = mepc;
      CSR_MCAUSE:  rdata = mcause;
      default:     rdata = '0;
    endcase
  end

endmodule

/* design/exec_stage.sv */
`include "rv_exec_defines.svh"

module exec_stage (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         prev_valid,
  input  logic                         next_ready,
  input  logic [`RV_EXEC_XLEN-1:0]     pc,
  input  rv_decode_pkg::inst_word_u    inst,
  input  logic [`RV_EXEC_XLEN-1:0]     imm,
  input  logic [`RV_EXEC_XLEN-1:0]     op1,
  input  logic [`RV_EXEC_XLEN-1:0]     op2,
  input  logic [`RV_EXEC_XLEN-1:0]     opj,
  input  rv_decode_pkg::alu_op_t       alu_op,
  input  logic [3:0]                   rd,
  input  logic                         ren,
  input  logic                         wen,
  input  logic                         jen,
  input  logic                         ben,
  input  logic                         system,
  input  logic                         csr_wen,
  input  logic                         ebreak,
  input  logic                         ecall,
  input  logic                         mret,
  input  logic [`RV_EXEC_XLEN-1:0]     lsu_rdata,
  input  logic                         lsu_rvalid,
  input  logic                         lsu_wready,
  output logic                         lsu_avalid,
  output logic                         lsu_ren,
  output logic                         lsu_wen,
  output logic [`RV_EXEC_XLEN-1:0]     lsu_addr,
  output logic [`RV_EXEC_XLEN-1:0]     lsu_wdata,
  output logic                         valid,
  output logic                         ready,
  output logic [`RV_EXEC_XLEN-1:0]     reg_wdata,
  output logic [3:0]                   rd_out,
  output logic [`RV_EXEC_XLEN-1:0]     npc,
  output logic                         branch_change,
  output logic                         branch_retire,
  output logic                         load_retire,
  output logic                         ebreak_out,
  output logic [`RV_EXEC_XLEN-1:0]     pc_out,
  output rv_decode_pkg::inst_word_u    inst_out
);
  import rv_decode_pkg::*;
  import rv_csr_pkg::*;

  inst_word_u               inst_q;
  alu_op_t                  alu_op_q;
  logic [`RV_EXEC_XLEN-1:0] pc_q;
  logic [`RV_EXEC_XLEN-1:0] imm_q;
  logic [`RV_EXEC_XLEN-1:0] op1_q;
  logic [`RV_EXEC_XLEN-1:0] op2_q;
  logic [`RV_EXEC_XLEN-1:0] opj_q;
  logic [`RV_EXEC_XLEN-1:0] mem_rdata;
  logic [3:0]               rd_q;
  logic ren_q, wen_q, jen_q, ben_q;
  logic system_q, csr_wen_q, ebreak_q, ecall_q, mret_q;

  logic alu_valid;
  logic lsu_valid;
  logic ready_q;
  logic accept;
  logic mem_done;

  logic [`RV_EXEC_XLEN-1:0] alu_result;
  logic [`RV_EXEC_XLEN-1:0] rwaddr;
  logic [`RV_EXEC_XLEN-1:0] csr_rdata;
  logic [`RV_EXEC_XLEN-1:0] csr_wdata;
  logic [`RV_EXEC_XLEN-1:0] mepc;
  logic [`RV_EXEC_XLEN-1:0] mtvec;
  logic [2:0]               funct3;
  csr_addr_t                csr_addr;

  // no new work while the result is stuck downstream.
  assign accept   = prev_valid & ready_q & next_ready;
  assign mem_done = (wen_q & lsu_wready) | (ren_q & lsu_rvalid);

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_valid  <= 1'b0;
      lsu_valid  <= 1'b0;
      lsu_avalid <= 1'b0;
      ready_q    <= 1'b1;
      ren_q      <= 1'b0;
      wen_q      <= 1'b0;
      jen_q      <= 1'b0;
      ben_q      <= 1'b0;
      system_q   <= 1'b0;
      csr_wen_q  <= 1'b0;
      ebreak_q   <= 1'b0;
      ecall_q    <= 1'b0;
      mret_q     <= 1'b0;
    end else begin
      if (accept) begin
        ren_q     <= ren;
        wen_q     <= wen;
        jen_q     <= jen;
        ben_q     <= ben;
        system_q  <= system;
        csr_wen_q <= csr_wen;
        ebreak_q  <= ebreak;
        ecall_q   <= ecall;
        mret_q    <= mret;
        alu_valid <= 1'b1;
        if (wen | ren) begin
          lsu_avalid <= 1'b1; // hold until the memory answers.
          ready_q    <= 1'b0;
        end
      end else if (next_ready) begin
        alu_valid <= 1'b0;
      end
      if (next_ready) begin
        lsu_valid <= 1'b0;
      end
      if (mem_done) begin
        lsu_valid  <= 1'b1;
        lsu_avalid <= 1'b0;
        ready_q    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pc_q     <= pc;
      inst_q   <= inst;
      imm_q    <= imm;
      op1_q    <= op1;
      op2_q    <= op2;
      opj_q    <= opj;
      alu_op_q <= alu_op;
      rd_q     <= rd;
    end
    if (ren_q && lsu_rvalid) begin
      mem_rdata <= lsu_rdata;
    end
  end

  assign valid = (wen_q | ren_q) ? lsu_valid : alu_valid;
  assign ready = ready_q & next_ready;

  assign rwaddr    = opj_q + imm_q;
  assign lsu_ren   = ren_q;
  assign lsu_wen   = wen_q;
  assign lsu_addr  = rwaddr;
  assign lsu_wdata = op2_q;

  exec_alu alu (
    .a      (op1_q),
    .b      (op2_q),
    .op     (alu_op_q),
    .result (alu_result)
  );

  assign funct3   = inst_q.r_view.funct3;
  assign csr_addr = inst_q.i_view.imm12;

  always_comb begin
    case (funct3)
      `RV_EXEC_F3_CSRRW, `RV_EXEC_F3_CSRRWI: csr_wdata = op1_q;
      `RV_EXEC_F3_CSRRS, `RV_EXEC_F3_CSRRSI: csr_wdata = csr_rdata | op1_q;
      `RV_EXEC_F3_CSRRC, `RV_EXEC_F3_CSRRCI: csr_wdata = csr_rdata & ~op1_q;
      default:                               csr_wdata = '0;
    endcase
  end

  // csr state changes once, at the edge the result is handed on.
  exec_csr_file csr (
    .clock (clock),
    .reset (reset),
    .wen   (csr_wen_q & valid),
    .valid (valid & next_ready),
    .ecall (ecall_q),
    .mret  (mret_q),
    .addr  (csr_addr),
    .wdata (csr_wdata),
    .pc    (pc_q),
    .rdata (csr_rdata),
    .mepc  (mepc),
    .mtvec (mtvec)
  );

  // x0 always reads zero.
  assign reg_wdata = (rd_q == 4'd0) ? '0 :
                     ren_q          ? mem_rdata :
                     system_q       ? csr_rdata : alu_result;

  always_comb begin
    if (ben_q) begin
      case (alu_op_q)
        `RV_EXEC_ALU_SUB: branch_change = ~|alu_result; // beq.
        `RV_EXEC_ALU_XOR, `RV_EXEC_ALU_SLT, `RV_EXEC_ALU_SLTU,
        `RV_EXEC_ALU_SLE, `RV_EXEC_ALU_SLEU: branch_change = |alu_result;
        default: branch_change = 1'b0;
      endcase
    end else begin
      branch_change = jen_q | ecall_q | mret_q;
    end
  end

  assign npc = ecall_q       ? mtvec :
               mret_q        ? mepc :
               branch_change ? rwaddr : pc_q + 4;

  assign branch_retire = system_q | ben_q | ren_q;
  assign load_retire   = ren_q & valid;
  assign rd_out        = rd_q;
  assign ebreak_out    = ebreak_q;
  assign pc_out        = pc_q;
  assign inst_out      = inst_q;

endmodule

/* design/exec_data_ram.sv */
`include "rv_exec_defines.svh"

module exec_data_ram (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         avalid,
  input  logic                         ren,
  input  logic                         wen,
  input  logic [`RV_EXEC_XLEN-1:0]     addr,
  input  logic [`RV_EXEC_XLEN-1:0]     wdata,
  output logic [`RV_EXEC_XLEN-1:0]     rdata,
  output logic                         rvalid,
  output logic                         wready
);

  localparam int AW = $clog2(`RV_EXEC_MEM_WORDS);

  logic [`RV_EXEC_XLEN-1:0] mem [`RV_EXEC_MEM_WORDS];
  logic [AW-1:0]            word_addr;
  logic                     busy;
  logic                     serve;

  assign word_addr = addr[AW+1:2]; // word aligned only.

  // one answer per request, then wait for avalid to drop.
  assign serve = avalid & ~busy & ~reset;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy   <= 1'b0;
      rvalid <= 1'b0;
      wready <= 1'b0;
    end else begin
      rvalid <= 1'b0;
      wready <= 1'b0;
      if (!avalid) begin
        busy <= 1'b0;
      end else if (serve) begin
        busy   <= 1'b1;
        rvalid <= ren;
        wready <= wen;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (serve && wen) begin
      mem[word_addr] <= wdata;
    end
    if (serve && ren) begin
      rdata <= mem[word_addr];
    end
  end

endmodule

/* design/rv_exec_top.sv */
`include "rv_exec_defines.svh"

module rv_exec_top (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         prev_valid,
  input  logic                         next_ready,
  input  logic [`RV_EXEC_XLEN-1:0]     pc,
  input  rv_decode_pkg::inst_word_u    inst,
  input  logic [`RV_EXEC_XLEN-1:0]     imm,
  input  logic [`RV_EXEC_XLEN-1:0]     op1,
  input  logic [`RV_EXEC_XLEN-1:0]     op2,
  input  logic [`RV_EXEC_XLEN-1:0]     opj,
  input  rv_decode_pkg::alu_op_t       alu_op,
  input  logic [3:0]                   rd,
  input  logic                         ren,
  input  logic                         wen,
  input  logic                         jen,
  input  logic                         ben,
  input  logic                         system,
  input  logic                         csr_wen,
  input  logic                         ebreak,
  input  logic                         ecall,
  input  logic                         mret,
  output logic                         valid,
  output logic                         ready,
  output logic [`RV_EXEC_XLEN-1:0]     reg_wdata,
  output logic [3:0]                   rd_out,
  output logic [`RV_EXEC_XLEN-1:0]     npc,
  output logic                         branch_change,
  output logic                         branch_retire,
  output logic                         load_retire,
  output logic                         ebreak_out,
  output logic [`RV_EXEC_XLEN-1:0]     pc_out,
  output rv_decode_pkg::inst_word_u    inst_out
);

  // stage to memory.
  logic                     lsu_avalid;
  logic                     lsu_ren;
  logic                     lsu_wen;
  logic [`RV_EXEC_XLEN-1:0] lsu_addr;
  logic [`RV_EXEC_XLEN-1:0] lsu_wdata;
  logic [`RV_EXEC_XLEN-1:0] lsu_rdata;
  logic                     lsu_rvalid;
  logic                     lsu_wready;

  exec_stage stage (
    .clock         (clock),
    .reset         (reset),
    .prev_valid    (prev_valid),
    .next_ready    (next_ready),
    .pc            (pc),
    .inst          (inst),
    .imm           (imm),
    .op1           (op1),
    .op2           (op2),
    .opj           (opj),
    .alu_op        (alu_op),
    .rd            (rd),
    .ren           (ren),
    .wen           (wen),
    .jen           (jen),
    .ben           (ben),
    .system        (system),
    .csr_wen       (csr_wen),
    .ebreak        (ebreak),
    .ecall         (ecall),
    .mret          (mret),
    .lsu_rdata     (lsu_rdata),
    .lsu_rvalid    (lsu_rvalid),
    .lsu_wready    (lsu_wready),
    .lsu_avalid    (lsu_avalid),
    .lsu_ren       (lsu_ren),
    .lsu_wen       (lsu_wen),
    .lsu_addr      (lsu_addr),
    .lsu_wdata     (lsu_wdata),
    .valid         (valid),
    .ready         (ready),
    .reg_wdata     (reg_wdata),
    .rd_out        (rd_out),
    .npc           (npc),
    .branch_change (branch_change),
    .branch_retire (branch_retire),
    .load_retire   (load_retire),
    .ebreak_out    (ebreak_out),
    .pc_out        (pc_out),
    .inst_out      (inst_out)
  );

  exec_data_ram ram (
    .clock  (clock),
    .reset  (reset),
    .avalid (lsu_avalid),
    .ren    (lsu_ren),
    .wen    (lsu_wen),
    .addr   (lsu_addr),
    .wdata  (lsu_wdata),
    .rdata  (lsu_rdata),
    .rvalid (lsu_rvalid),
    .wready (lsu_wready)
  );

endmodule

/* tests/rv_exec_asserts.sv */
`include "rv_exec_defines.svh"

module rv_exec_asserts (
  input logic                     clock,
  input logic                     reset,
  input logic                     valid,
  input logic                     next_ready,
  input logic [`RV_EXEC_XLEN-1:0] reg_wdata,
  input logic [`RV_EXEC_XLEN-1:0] npc,
  input logic                     lsu_avalid,
  input logic                     lsu_rvalid,
  input logic                     lsu_wready
);

  // nothing valid right after reset.
  valid_after_reset: assert property (@(posedge clock) reset |=> !valid)
    else $error("valid high in the cycle after reset");

  // result holds while downstream stalls.
  hold_under_stall: assert property (@(posedge clock) disable iff (reset)
    (valid && !next_ready) |=> ($stable(reg_wdata) && $stable(npc)))
    else $error("result changed while next_ready was low");

  request_drops: assert property (@(posedge clock) disable iff (reset)
    (lsu_rvalid || lsu_wready) |=> !lsu_avalid)
    else $error("lsu_avalid still high after the memory answered");

endmodule

bind exec_stage rv_exec_asserts asserts (
  .clock      (clock),
  .reset      (reset),
  .valid      (valid),
  .next_ready (next_ready),
  .reg_wdata  (reg_wdata),
  .npc        (npc),
  .lsu_avalid (lsu_avalid),
  .lsu_rvalid (lsu_rvalid),
  .lsu_wready (lsu_wready)
);

/* tests/rv_exec_tb.sv */
`include "rv_exec_defines.svh"

module rv_exec_tb;
  import rv_decode_pkg::*;
  import rv_csr_pkg::*;

  // a few cycles per instruction at most, ten leaves margin.
  localparam int TEST_INSTRS = 88;
  localparam int WATCHDOG_CYCLES = TEST_INSTRS * 10 + 100;
  localparam logic [31:0] TRAP_VECTOR = 32'h0000_0400;

  logic        clock = 1'b0;
  logic        reset;
  logic        prev_valid;
  logic        next_ready;
  logic [31:0] pc;
  inst_word_u  inst;
  logic [31:0] imm;
  logic [31:0] op1;
  logic [31:0] op2;
  logic [31:0] opj;
  alu_op_t     alu_op;
  logic [3:0]  rd;
  logic        ren;
  logic        wen;
  logic        jen;
  logic        ben;
  logic        system;
  logic        csr_wen;
  logic        ebreak;
  logic        ecall;
  logic        mret;
  logic        valid;
  logic        ready;
  logic [31:0] reg_wdata;
  logic [3:0]  rd_out;
  logic [31:0] npc;
  logic        branch_change;
  logic        branch_retire;
  logic        load_retire;
  logic        ebreak_out;
  logic [31:0] pc_out;
  inst_word_u  inst_out;

  logic [31:0] rand_state = 32'h3354_8ad5;
  logic [31:0] shadow_mem [256];
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;

  rv_exec_top uut (.*);

  always #10 clock = ~clock;

  function automatic logic [31:0] next_random();
    rand_state ^= rand_state << 13;
    rand_state ^= rand_state >> 17;
    rand_state ^= rand_state << 5;
    return rand_state;
  endfunction

  function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      `RV_EXEC_ALU_ADD:  return a + b;
      `RV_EXEC_ALU_SUB:  return a - b;
      `RV_EXEC_ALU_SLL:  return a << b[4:0];
      `RV_EXEC_ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
      `RV_EXEC_ALU_SLTU: return {31'd0, a < b};
      `RV_EXEC_ALU_XOR:  return a ^ b;
      `RV_EXEC_ALU_SRL:  return a >> b[4:0];
      `RV_EXEC_ALU_SRA:  return $signed(a) >>> b[4:0];
      `RV_EXEC_ALU_OR:   return a | b;
      `RV_EXEC_ALU_AND:  return a & b;
      `RV_EXEC_ALU_SLE:  return {31'd0, $signed(a) <= $signed(b)};
      `RV_EXEC_ALU_SLEU: return {31'd0, a <= b};
      default:           return 32'd0;
    endcase
  endfunction

  task automatic clear_bundle;
    pc      = 32'd0;
    inst    = '0;
    imm     = 32'd0;
    op1     = 32'd0;
    op2     = 32'd0;
    opj     = 32'd0;
    alu_op  = `RV_EXEC_ALU_ADD;
    rd      = 4'd0;
    ren     = 1'b0;
    wen     = 1'b0;
    jen     = 1'b0;
    ben     = 1'b0;
    system  = 1'b0;
    csr_wen = 1'b0;
    ebreak  = 1'b0;
    ecall   = 1'b0;
    mret    = 1'b0;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  // hands one bundle over and returns at the falling edge where valid is seen.
  task automatic issue;
    logic is_mem;
    logic retire;
    is_mem = ren | wen;
    retire = system | ben | ren;
    while (!ready) @(negedge clock);
    prev_valid = 1'b1;
    @(posedge clock);
    @(negedge clock);
    prev_valid = 1'b0;
    while (!valid) begin
      if (is_mem && ready) begin
        $display("ready went high at time %0t before the memory access finished", $time);
        errors++;
      end
      @(negedge clock);
    end
    // fields passed through with the result.
    if (rd_out !== rd) report_mismatch("rd_out", {28'd0, rd_out}, {28'd0, rd});
    if (pc_out !== pc) report_mismatch("pc_out", pc_out, pc);
    if (inst_out !== inst) report_mismatch("inst_out", inst_out, inst);
    if (branch_retire !== retire) begin
      report_mismatch("branch_retire", {31'd0, branch_retire}, {31'd0, retire});
    end
  endtask

  task automatic end_of_test(input string name, input int start);
    if (errors == start) begin
      $display("%s: ok", name);
      passed++;
    end else begin
      $display("%s: %0d errors", name, errors - start);
      failed++;
    end
  endtask

  task automatic alu_ops;
    int          start;
    logic [31:0] exp;
    start = errors;
    for (int i = 0; i < 41; i++) begin
      clear_bundle();
      pc     = next_random() & 32'hffff_fffc;
      op1    = next_random();
      op2    = next_random();
      alu_op = (i == 40) ? `RV_EXEC_ALU_OR : 4'(i % 12);
      rd     = (i == 40) ? 4'd0 : 4'(1 + i % 15); // last one targets x0.
      exp    = (i == 40) ? 32'd0 : alu_model(alu_op, op1, op2);
      issue();
      if (reg_wdata !== exp) report_mismatch("alu result", reg_wdata, exp);
      if (npc !== pc + 32'd4) report_mismatch("alu npc", npc, pc + 32'd4);
    end
    end_of_test("alu operations", start);
  endtask

  task automatic mem_access(input logic is_load, input logic [7:0] w);
    logic [31:0] r;
    logic [31:0] addr;
    r = next_random();
    clear_bundle();
    addr = {22'd0, w, 2'b00};
    imm  = {20'd0, r[31:22], 2'b00};
    opj  = addr - imm; // sum lands back on addr.
    ren  = is_load;
    wen  = ~is_load;
    rd   = is_load ? 4'd5 : 4'd0;
    op2  = next_random();
    if (!is_load) shadow_mem[w] = op2;
    issue();
    if (is_load && reg_wdata !== shadow_mem[w]) begin
      report_mismatch("load data", reg_wdata, shadow_mem[w]);
    end
    if (load_retire !== is_load) begin
      report_mismatch("load_retire", {31'd0, load_retire}, {31'd0, is_load});
    end
  endtask

  task automatic loads_and_stores;
    int          start;
    logic [31:0] r;
    logic [7:0]  stored [$];
    start = errors;
    for (int i = 0; i < 8; i++) begin
      r = next_random();
      stored.push_back(r[7:0]);
      mem_access(1'b0, r[7:0]);
    end
    while (stored.size() > 0) begin
      mem_access(1'b1, stored.pop_front());
    end
    end_of_test("loads and stores", start);
  endtask

  task automatic branches_and_jumps;
    int          start;
    logic [31:0] x;
    logic [31:0] y;
    logic        taken;
    start = errors;
    for (int k = 0; k < 4; k++) begin
      for (int c = 0; c < 3; c++) begin
        // equal, less, greater.
        x = (c == 1) ? 32'hffff_fffd : ((c == 0) ? 32'd5 : 32'd7);
        y = (c == 2) ? 32'hffff_fffd : ((c == 0) ? 32'd5 : 32'd7);
        clear_bundle();
        ben = 1'b1;
        pc  = 32'h0000_1000 + 32'(k * 16 + c * 4);
        opj = pc;
        imm = 32'h0000_0080;
        op1 = (k == 3) ? y : x; // bge runs as y <= x.
        op2 = (k == 3) ? x : y;
        case (k)
          0: begin
            alu_op = `RV_EXEC_ALU_SUB;
            taken  = (x == y);
          end
          1: begin
            alu_op = `RV_EXEC_ALU_XOR;
            taken  = (x != y);
          end
          2: begin
            alu_op = `RV_EXEC_ALU_SLT;
            taken  = ($signed(x) < $signed(y));
          end
          default: begin
            alu_op = `RV_EXEC_ALU_SLE;
            taken  = ($signed(x) >= $signed(y));
          end
        endcase
        issue();
        if (branch_change !== taken) begin
          report_mismatch("branch taken", {31'd0, branch_change}, {31'd0, taken});
        end
        if (npc !== (taken ? opj + imm : pc + 32'd4)) begin
          report_mismatch("branch npc", npc, taken ? opj + imm : pc + 32'd4);
        end
      end
    end
    clear_bundle();
    jen = 1'b1;
    pc  = 32'h0000_2000;
    opj = pc;
    imm = 32'h0000_0800;
    op1 = pc;
    op2 = 32'd4; // link value.
    rd  = 4'd1;
    issue();
    if (branch_change !== 1'b1) report_mismatch("jal redirect", {31'd0, branch_change}, 32'd1);
    if (npc !== pc + imm) report_mismatch("jal npc", npc, pc + imm);
    if (reg_wdata !== pc + 32'd4) report_mismatch("jal link", reg_wdata, pc + 32'd4);
    end_of_test("branches and jumps", start);
  endtask

  task automatic csr_access(input logic [2:0] f3, input csr_addr_t addr,
                            input logic [31:0] value, input logic write,
                            input logic [31:0] old);
    clear_bundle();
    system  = 1'b1;
    csr_wen = write;
    rd      = 4'd3;
    op1     = value;
    inst    = {addr, 5'd0, f3, 5'd3, 7'h73};
    issue();
    if (reg_wdata !== old) report_mismatch("csr old value", reg_wdata, old);
  endtask

  task automatic csr_ops;
    int          start;
    logic [31:0] r;
    logic [31:0] status;
    start = errors;
    r = next_random();
    csr_access(`RV_EXEC_F3_CSRRW, CSR_MTVEC, r, 1'b1, 32'd0);
    csr_access(`RV_EXEC_F3_CSRRW, CSR_MTVEC, TRAP_VECTOR, 1'b1, r);
    status = next_random();
    csr_access(`RV_EXEC_F3_CSRRS, CSR_MSTATUS, status, 1'b1, 32'd0);
    r = next_random();
    csr_access(`RV_EXEC_F3_CSRRS, CSR_MSTATUS, r, 1'b1, status);
    status = status | r;
    csr_access(`RV_EXEC_F3_CSRRS, CSR_MSTATUS, 32'd0, 1'b0, status); // plain read.
    r = next_random();
    csr_access(`RV_EXEC_F3_CSRRC, CSR_MSTATUS, r, 1'b1, status);
    status = status & ~r;
    csr_access(`RV_EXEC_F3_CSRRS, CSR_MSTATUS, 32'd0, 1'b0, status);
    // immediate forms, op1 carries the zero extended uimm.
    csr_access(`RV_EXEC_F3_CSRRWI, CSR_MSTATUS, 32'd21, 1'b1, status);
    status = 32'd21;
    csr_access(`RV_EXEC_F3_CSRRSI, CSR_MSTATUS, 32'd10, 1'b1, status);
    status = status | 32'd10;
    csr_access(`RV_EXEC_F3_CSRRSI, CSR_MSTATUS, 32'd0, 1'b0, status);
    csr_access(`RV_EXEC_F3_CSRRCI, CSR_MSTATUS, 32'd3, 1'b1, status);
    status = status & ~32'd3;
    csr_access(`RV_EXEC_F3_CSRRSI, CSR_MSTATUS, 32'd0, 1'b0, status);
    end_of_test("csr operations", start);
  endtask

  task automatic trap_entry_return;
    int start;
    start = errors;
    clear_bundle();
    system = 1'b1;
    ecall  = 1'b1;
    pc     = 32'h0000_0a40;
    issue();
    if (npc !== TRAP_VECTOR) report_mismatch("ecall npc", npc, TRAP_VECTOR);
    if (branch_change !== 1'b1) report_mismatch("ecall redirect", {31'd0, branch_change}, 32'd1);
    csr_access(`RV_EXEC_F3_CSRRS, CSR_MEPC, 32'd0, 1'b0, 32'h0000_0a40);
    clear_bundle();
    system = 1'b1;
    mret   = 1'b1;
    pc     = 32'h0000_0500;
    issue();
    if (npc !== 32'h0000_0a40) report_mismatch("mret npc", npc, 32'h0000_0a40);
    if (ebreak_out !== 1'b0) report_mismatch("ebreak on mret", {31'd0, ebreak_out}, 32'd0);
    clear_bundle();
    system = 1'b1;
    ebreak = 1'b1;
    pc     = 32'h0000_0b00;
    issue();
    if (ebreak_out !== 1'b1) report_mismatch("ebreak flag", {31'd0, ebreak_out}, 32'd1);
    end_of_test("trap entry and return", start);
  endtask

  task automatic back_pressure;
    int          start;
    logic [31:0] held_data;
    logic [31:0] held_npc;
    start = errors;
    clear_bundle();
    op1 = next_random();
    op2 = next_random();
    rd  = 4'd2;
    pc  = 32'h0000_3000;
    issue();
    held_data = reg_wdata;
    held_npc  = npc;
    if (held_data !== op1 + op2) report_mismatch("stalled result", held_data, op1 + op2);
    next_ready = 1'b0;
    clear_bundle();
    op1        = next_random();
    op2        = next_random();
    alu_op     = `RV_EXEC_ALU_XOR;
    rd         = 4'd4;
    pc         = 32'h0000_3100;
    prev_valid = 1'b1; // offered but must wait.
    repeat (5) begin
      @(negedge clock);
      if (valid !== 1'b1) begin
        $display("valid dropped at time %0t while next_ready was low", $time);
        errors++;
      end
      if (ready !== 1'b0) begin
        $display("ready was high at time %0t while next_ready was low", $time);
        errors++;
      end
      if (reg_wdata !== held_data) report_mismatch("held reg_wdata", reg_wdata, held_data);
      if (npc !== held_npc) report_mismatch("held npc", npc, held_npc);
    end
    next_ready = 1'b1;
    @(posedge clock);
    @(negedge clock);
    prev_valid = 1'b0;
    if (valid !== 1'b1) begin
      $display("no result at time %0t after next_ready was released", $time);
      errors++;
    end
    if (reg_wdata !== (op1 ^ op2)) report_mismatch("result after stall", reg_wdata, op1 ^ op2);
    if (npc !== pc + 32'd4) report_mismatch("npc after stall", npc, pc + 32'd4);
    end_of_test("back-pressure", start);
  endtask

  initial begin
    reset      = 1'b1;
    prev_valid = 1'b0;
    next_ready = 1'b1;
    clear_bundle();
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    alu_ops();
    loads_and_stores();
    branches_and_jumps();
    csr_ops();
    trap_entry_return();
    back_pressure();
    $display("summary: %0d tests passed, %0d failed", passed, failed);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* rv_exec.f */
+incdir+design
design/rv_decode_pkg.sv
design/rv_csr_pkg.sv
design/exec_alu.sv
design/exec_csr_file.sv
design/exec_stage.sv
design/exec_data_ram.sv
design/rv_exec_top.sv
tests/rv_exec_asserts.sv
tests/rv_exec_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module rv_exec_tb -f rv_exec.f &&
  ./obj_dir/Vrv_exec_tb | tee /dev/stderr | grep -x "TEST PASS" > /dev/null &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
